// File: common/mac_tx_pkg.sv
`default_nettype none

package mac_tx_pkg;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////
    typedef logic [7:0]  byte_t;       // frame or gmii byte
    typedef logic [10:0] frame_len_t;  // length without preamble and fcs
    typedef logic [10:0] byte_idx_t;   // 0 at first destination byte
    typedef logic [15:0] ptr_word_t;
    typedef logic [31:0] ns_t;
    typedef logic [47:0] cf_hi_t;      // upper 48 bits of correctionField

    // one fetched byte with its framing
    typedef struct packed {
        logic      valid;
        logic      last;
        byte_idx_t idx;
        byte_t     data;
    } tx_stream_t;

    ////////////////////////////////////////
    // ptp layout, byte offsets from the DA
    ////////////////////////////////////////
    localparam byte_t     PTP_ETYPE_HI  = 8'h88;
    localparam byte_t     PTP_ETYPE_LO  = 8'hf7;
    localparam byte_idx_t IDX_ETYPE     = 11'd12;  // lo byte at 13
    localparam byte_idx_t IDX_MSGTYPE   = 11'd14;
    localparam logic [3:0] PTP_TYPE_SYNC = 4'h0;
    localparam logic [3:0] PTP_TYPE_FLUP = 4'h8;
    localparam byte_idx_t IDX_CF_FIRST  = 11'd22;
    localparam byte_idx_t IDX_CF_LAST   = 11'd27;
    localparam byte_idx_t IDX_TS_FIRST  = 11'd54;  // originTimestamp ns, msb first
    localparam byte_idx_t IDX_TS_LAST   = 11'd57;

    // framing on the wire
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;
    localparam int    PREAMBLE_LEN  = 8;     // sfd included
    localparam int    CRC_LEN       = 4;
    localparam int    IFG_CYCLES    = 12;
    localparam int    MIN_FRAME_LEN = 60;
    localparam int    BUF_DEPTH     = 8;     // cf rewrite delay line

    localparam logic [31:0] CRC_POLY_REFL = 32'hedb8_8320;  // 0x04c11db7 reversed
    localparam logic [31:0] CRC_INIT      = 32'hffff_ffff;

    typedef enum logic [2:0] {
        F_IDLE, F_PTR_RD, F_PTR_USE, F_DATA, F_WAIT_EMIT
    } fetch_state_e;

    typedef enum logic [2:0] {
        E_IDLE, E_PREAMBLE, E_FRAME, E_CRC, E_GAP
    } emit_state_e;

endpackage

`default_nettype wire

// File: verilog/crc32_8023.sv
`timescale 1ns/1ns
`default_nettype none

module crc32_8023 (
    input  logic              tx_master_clk,
    input  logic              rstn_mac,
    input  logic              load_init,
    input  logic              calc,
    input  logic              d_valid,
    input  mac_tx_pkg::byte_t d,
    output mac_tx_pkg::byte_t crc_byte
);
    import mac_tx_pkg::*;

    logic [31:0] crc_q;

    // one byte of the reflected crc, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input byte_t b);
        logic [31:0] r;
        r = c ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY_REFL) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_q <= CRC_INIT;
        end else if (load_init) begin
            crc_q <= CRC_INIT;
        end else if (d_valid) begin
            if (calc) begin
                crc_q <= crc_step(crc_q, d);
            end else begin
                crc_q <= {8'hff, crc_q[31:8]};   // shift out, next byte low
            end
        end
    end

    assign crc_byte = ~crc_q[7:0];   // fcs is the complement

endmodule

`default_nettype wire

// File: verilog/mac_tx_emit.sv
`timescale 1ns/1ns
`default_nettype none

module mac_tx_emit (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    input  mac_tx_pkg::tx_stream_t buf_stream,
    input  logic                   frame_start,
    output logic                   emit_busy,
    output logic                   gtx_dv,
    output mac_tx_pkg::byte_t      gtx_d
);
    import mac_tx_pkg::*;

    emit_state_e state;
    logic [3:0]  cnt;          // preamble, crc and gap count
    logic        crc_init;
    logic        crc_calc;
    logic        crc_dv;
    byte_t       crc_byte;

    assign emit_busy = (state != E_IDLE);

    // crc runs over buffered bytes then shifts out
    assign crc_init = (state == E_IDLE) && frame_start;
    assign crc_calc = (state == E_FRAME);
    assign crc_dv   = ((state == E_FRAME) && buf_stream.valid) || (state == E_CRC);

    ////////////////////////////////////////
    // output sequencer
    ////////////////////////////////////////
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state  <= E_IDLE;
            cnt    <= '0;
            gtx_dv <= 1'b0;
            gtx_d  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                E_IDLE: begin
                    // first preamble byte leaves right away
                    gtx_dv <= frame_start;
                    gtx_d  <= frame_start ? PREAMBLE_BYTE : 8'h00;
                    cnt    <= 4'd1;
                    if (frame_start) begin
                        state <= E_PREAMBLE;
                    end
                end
                E_PREAMBLE: begin
                    gtx_d <= (cnt == PREAMBLE_LEN - 1) ? SFD_BYTE : PREAMBLE_BYTE;
                    if (cnt == PREAMBLE_LEN - 1) begin
                        state <= E_FRAME;   // first buffered byte is due
                    end
                end
                E_FRAME: begin
                    gtx_d <= buf_stream.data;
                    cnt   <= '0;
                    if (buf_stream.last) begin
                        state <= E_CRC;
                    end
                end
                E_CRC: begin
                    gtx_d <= crc_byte;
                    if (cnt == CRC_LEN - 1) begin
                        state <= E_GAP;
                        cnt   <= '0;
                    end
                end
                E_GAP: begin
                    gtx_dv <= 1'b0;
                    gtx_d  <= 8'h00;
                    if (cnt == IFG_CYCLES - 1) begin
                        state <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    crc32_8023 u_crc (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .load_init     (crc_init),
        .calc          (crc_calc),
        .d_valid       (crc_dv),
        .d             (buf_stream.data),
        .crc_byte      (crc_byte)
    );

    // no new frame may arrive while the gap runs
    a_gap_quiet: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (state == E_GAP) |-> !frame_start);

endmodule

`default_nettype wire

// File: ptp/ptp_tx_parser.sv
`timescale 1ns/1ns
`default_nettype none

module ptp_tx_parser (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    input  mac_tx_pkg::tx_stream_t fetch_stream,
    input  mac_tx_pkg::ns_t        counter_ns,
    output logic                   cf_rewrite_en,
    output mac_tx_pkg::ns_t        sync_delay
);
    import mac_tx_pkg::*;

    logic etype_hi;     // 0x88 seen at IDX_ETYPE
    logic is_ptp;
    logic is_sync;
    ns_t  t_now;        // local time when the timestamp field passes
    ns_t  t_origin;     // originTimestamp ns from the frame

    ////////////////////////////////////////
    // header match at fixed offsets
    ////////////////////////////////////////
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            etype_hi      <= 1'b0;
            is_ptp        <= 1'b0;
            is_sync       <= 1'b0;
            cf_rewrite_en <= 1'b0;
            sync_delay    <= '0;
        end else if (fetch_stream.valid) begin
            case (fetch_stream.idx)
                IDX_ETYPE: begin
                    etype_hi <= (fetch_stream.data == PTP_ETYPE_HI);
                end
                IDX_ETYPE + 1'b1: begin
                    is_ptp <= etype_hi && (fetch_stream.data == PTP_ETYPE_LO);
                end
                IDX_MSGTYPE: begin
                    is_sync       <= is_ptp && (fetch_stream.data[3:0] == PTP_TYPE_SYNC);
                    cf_rewrite_en <= is_ptp && (fetch_stream.data[3:0] == PTP_TYPE_FLUP);
                end
                default: ;
            endcase
            if (fetch_stream.last) begin
                if (is_sync) begin
                    sync_delay <= t_now - t_origin;   // wraps mod 2^32
                end
                is_sync       <= 1'b0;
                cf_rewrite_en <= 1'b0;
            end
        end
    end

    // timestamp capture, sync frames only
    always_ff @(posedge tx_master_clk) begin
        if (fetch_stream.valid && is_sync) begin
            if (fetch_stream.idx == IDX_TS_FIRST) begin
                t_now <= counter_ns;
            end
            if (fetch_stream.idx >= IDX_TS_FIRST && fetch_stream.idx <= IDX_TS_LAST) begin
                t_origin <= {t_origin[23:0], fetch_stream.data};  // msb first
            end
        end
    end

endmodule

`default_nettype wire

// File: ptp/ptp_cf_rewrite.sv
`timescale 1ns/1ns
`default_nettype none

module ptp_cf_rewrite (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    input  mac_tx_pkg::tx_stream_t fetch_stream,
    input  logic                   cf_rewrite_en,
    input  mac_tx_pkg::ns_t        sync_delay,
    output mac_tx_pkg::tx_stream_t buf_stream
);
    import mac_tx_pkg::*;

    tx_stream_t line [BUF_DEPTH];   // line[0] newest
    tx_stream_t line_out;
    cf_hi_t     cf_sum;             // corrected field, msb first
    cf_hi_t     cf_shift;
    logic [2:0] cf_sel;
    logic       cf_act;             // sum pending for the byte at the output
    logic       in_cf;

    assign line_out = line[BUF_DEPTH-1];

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                line[i] <= '0;
            end
            cf_act <= 1'b0;
        end else begin
            line[0] <= fetch_stream;
            for (int i = 1; i < BUF_DEPTH; i++) begin
                line[i] <= line[i-1];
            end
            if (fetch_stream.valid && cf_rewrite_en && fetch_stream.idx == IDX_CF_LAST) begin
                cf_act <= 1'b1;
            end else if (line_out.valid && line_out.last) begin
                cf_act <= 1'b0;
            end
        end
    end

    // bytes 22..26 sit in line[4..0] while 27 comes in
    always_ff @(posedge tx_master_clk) begin
        if (fetch_stream.valid && fetch_stream.idx == IDX_CF_LAST) begin
            cf_sum <= {line[4].data, line[3].data, line[2].data,
                       line[1].data, line[0].data, fetch_stream.data}
                      + cf_hi_t'(sync_delay);
        end
    end

    ////////////////////////////////////////
    // byte substitution at the output
    ////////////////////////////////////////
    assign cf_sel   = 3'(IDX_CF_LAST - line_out.idx);   // 0 for the lsb
    assign cf_shift = cf_sum >> {cf_sel, 3'b000};
    assign in_cf    = cf_act && (line_out.idx >= IDX_CF_FIRST) && (line_out.idx <= IDX_CF_LAST);

    always_comb begin
        buf_stream = line_out;
        if (in_cf) begin
            buf_stream.data = cf_shift[7:0];
        end
    end

endmodule

`default_nettype wire

// File: fetch/mac_tx_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module mac_tx_fetch (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    output logic                   ptr_fifo_rd,
    output logic                   tptr_fifo_rd,
    output logic                   data_fifo_rd,
    output logic                   tdata_fifo_rd,
    input  mac_tx_pkg::ptr_word_t  ptr_fifo_din,
    input  mac_tx_pkg::ptr_word_t  tptr_fifo_din,
    input  logic                   ptr_fifo_empty,
    input  logic                   tptr_fifo_empty,
    input  mac_tx_pkg::byte_t      data_fifo_din,
    input  mac_tx_pkg::byte_t      tdata_fifo_din,
    input  logic                   emit_busy,
    output mac_tx_pkg::tx_stream_t fetch_stream
);
    import mac_tx_pkg::*;

    fetch_state_e state, state_next;
    logic         sel_tt;       // 1 = time-triggered queue
    frame_len_t   len;
    byte_idx_t    rd_idx;       // index of the byte being read
    logic         rd_last;
    ptr_word_t    ptr_word;
    logic         strm_valid;
    logic         strm_last;
    byte_idx_t    strm_idx;

    assign ptr_word = sel_tt ? tptr_fifo_din : ptr_fifo_din;
    assign rd_last  = (rd_idx == byte_idx_t'(len - 1'b1));

    ////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            F_IDLE: begin
                if (!emit_busy && (!ptr_fifo_empty || !tptr_fifo_empty)) begin
                    state_next = F_PTR_RD;
                end
            end
            F_PTR_RD:    state_next = F_PTR_USE;
            F_PTR_USE:   state_next = F_DATA;     // pointer word on din now
            F_DATA:      state_next = rd_last ? F_WAIT_EMIT : F_DATA;
            F_WAIT_EMIT: state_next = emit_busy ? F_IDLE : F_WAIT_EMIT;
            default:     state_next = F_IDLE;
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state      <= F_IDLE;
            sel_tt     <= 1'b0;
            len        <= '0;
            rd_idx     <= '0;
            strm_valid <= 1'b0;
            strm_last  <= 1'b0;
            strm_idx   <= '0;
        end else begin
            state <= state_next;
            if (state == F_IDLE) begin
                sel_tt <= !tptr_fifo_empty;    // tt queue always wins
                rd_idx <= '0;
            end
            if (state == F_PTR_USE) begin
                len <= ptr_word[10:0];
            end
            if (state == F_DATA) begin
                rd_idx <= rd_idx + 1'b1;
            end
            // byte shows up one cycle after its read
            strm_valid <= data_fifo_rd || tdata_fifo_rd;
            strm_last  <= (state == F_DATA) && rd_last;
            strm_idx   <= rd_idx;
        end
    end

    assign ptr_fifo_rd   = (state == F_PTR_RD) && !sel_tt;
    assign tptr_fifo_rd  = (state == F_PTR_RD) && sel_tt;
    assign data_fifo_rd  = (state == F_DATA) && !sel_tt;
    assign tdata_fifo_rd = (state == F_DATA) && sel_tt;

    assign fetch_stream = '{
        valid: strm_valid,
        last:  strm_last,
        idx:   strm_idx,
        data:  sel_tt ? tdata_fifo_din : data_fifo_din
    };

    // the latched queue choice must point at a queue that holds a frame
    a_ptr_rd_not_empty: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(ptr_fifo_rd && ptr_fifo_empty) && !(tptr_fifo_rd && tptr_fifo_empty));

    a_rd_within_len: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (data_fifo_rd || tdata_fifo_rd) |-> (rd_idx < len));

endmodule

`default_nettype wire

// File: verilog/mac_tx_gmii.sv
`timescale 1ns/1ns
`default_nettype none

module mac_tx_gmii (
    input  logic                  tx_master_clk,
    input  logic                  rstn_mac,
    // normal queue
    output logic                  ptr_fifo_rd,
    input  mac_tx_pkg::ptr_word_t ptr_fifo_din,
    input  logic                  ptr_fifo_empty,
    output logic                  data_fifo_rd,
    input  mac_tx_pkg::byte_t     data_fifo_din,
    input  logic                  data_fifo_empty,   // store and forward, not needed
    // time-triggered queue
    output logic                  tptr_fifo_rd,
    input  mac_tx_pkg::ptr_word_t tptr_fifo_din,
    input  logic                  tptr_fifo_empty,
    output logic                  tdata_fifo_rd,
    input  mac_tx_pkg::byte_t     tdata_fifo_din,
    input  logic                  tdata_fifo_empty,
    // 1588
    input  mac_tx_pkg::ns_t       counter_ns,
    output mac_tx_pkg::ns_t       sync_delay,
    // gmii
    output logic                  gtx_dv,
    output mac_tx_pkg::byte_t     gtx_d
);
    import mac_tx_pkg::*;

    tx_stream_t fetch_stream;   // straight from the fifos
    tx_stream_t buf_stream;     // 8 bytes later, cf patched
    logic       cf_rewrite_en;
    logic       emit_busy;

    mac_tx_fetch u_fetch (
        .tx_master_clk   (tx_master_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .data_fifo_rd    (data_fifo_rd),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .ptr_fifo_din    (ptr_fifo_din),
        .tptr_fifo_din   (tptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .tptr_fifo_empty (tptr_fifo_empty),
        .data_fifo_din   (data_fifo_din),
        .tdata_fifo_din  (tdata_fifo_din),
        .emit_busy       (emit_busy),
        .fetch_stream    (fetch_stream)
    );

    ptp_tx_parser u_parser (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .fetch_stream  (fetch_stream),
        .counter_ns    (counter_ns),
        .cf_rewrite_en (cf_rewrite_en),
        .sync_delay    (sync_delay)
    );

    ptp_cf_rewrite u_cf_rewrite (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .fetch_stream  (fetch_stream),
        .cf_rewrite_en (cf_rewrite_en),
        .sync_delay    (sync_delay),
        .buf_stream    (buf_stream)
    );

    mac_tx_emit u_emit (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .buf_stream    (buf_stream),
        .frame_start   (fetch_stream.valid),
        .emit_busy     (emit_busy),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

endmodule

`default_nettype wire

// File: verif/tb_mac_tx_model.svh
`ifndef TB_MAC_TX_MODEL_SVH
`define TB_MAC_TX_MODEL_SVH

////////////////////////////////////////
// software model of the tx path
////////////////////////////////////////
localparam int MAX_BATCH = 4;
localparam int MAX_BYTES = 256;

byte_t      frm      [MAX_BATCH][MAX_BYTES];
frame_len_t frm_len  [MAX_BATCH];
int         frm_kind [MAX_BATCH];       // 0 plain, 1 sync, 2 follow_up, 3 other ptp
logic       frm_tt   [MAX_BATCH];
byte_t      wire_exp [MAX_BYTES + 16];  // preamble, frame, fcs
int         wire_len;
ns_t        model_delay;                // what sync_delay should hold

// random frame of one kind into slot k
function automatic void make_frame(int k, int kind, frame_len_t len);
    frm_len[k]  = len;
    frm_kind[k] = kind;
    for (int i = 0; i < int'(len); i++) begin
        frm[k][i] = byte_t'($urandom);
    end
    if (kind == 0) begin
        if (frm[k][12] == 8'h88) begin
            frm[k][12] = 8'h08;         // stay clear of the ptp ethertype
        end
    end else begin
        frm[k][12] = 8'h88;
        frm[k][13] = 8'hf7;
        case (kind)
            1:       frm[k][14] = {frm[k][14][7:4], 4'h0};
            2:       frm[k][14] = {frm[k][14][7:4], 4'h8};
            default: frm[k][14] = {frm[k][14][7:4], 4'hb};   // announce
        endcase
    end
endfunction

// expected gmii bytes of slot k, updates the delay model on sync
function automatic void build_wire(int k, ns_t now_ns);
    logic [31:0] c;
    logic        fb;
    ns_t         ts;
    cf_hi_t      cf;
    int          n;
    n = int'(frm_len[k]);
    for (int i = 0; i < 7; i++) begin
        wire_exp[i] = 8'h55;
    end
    wire_exp[7] = 8'hd5;
    for (int i = 0; i < n; i++) begin
        wire_exp[8 + i] = frm[k][i];
    end
    if (frm_kind[k] == 1) begin
        ts = '0;
        for (int j = 0; j < 4; j++) begin
            ts = {ts[23:0], frm[k][54 + j]};
        end
        model_delay = now_ns - ts;
    end else if (frm_kind[k] == 2) begin
        cf = '0;
        for (int j = 0; j < 6; j++) begin
            cf = {cf[39:0], frm[k][22 + j]};
        end
        cf = cf + {16'h0000, model_delay};
        for (int j = 0; j < 6; j++) begin
            wire_exp[8 + 22 + j] = cf[47 - 8*j -: 8];
        end
    end
    // bit serial crc, lsb of each byte first
    c = 32'hffff_ffff;
    for (int i = 0; i < n; i++) begin
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ wire_exp[8 + i][b];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
    end
    c = ~c;
    for (int j = 0; j < 4; j++) begin
        wire_exp[8 + n + j] = c[8*j +: 8];
    end
    wire_len = 8 + n + 4;
endfunction

`endif

// File: verif/tb_mac_tx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mac_tx;
    import mac_tx_pkg::*;

    localparam int N_BATCHES  = 14;
    localparam int RX_TIMEOUT = 2000;   // cycles waiting for gtx_dv
    localparam int MAX_RX     = 300;    // longest frame is 212 on the wire

    logic      tx_master_clk;
    logic      rstn_mac;
    logic      ptr_fifo_rd;
    logic      tptr_fifo_rd;
    logic      data_fifo_rd;
    logic      tdata_fifo_rd;
    ptr_word_t ptr_fifo_din;
    ptr_word_t tptr_fifo_din;
    logic      ptr_fifo_empty;
    logic      tptr_fifo_empty;
    logic      data_fifo_empty;
    logic      tdata_fifo_empty;
    byte_t     data_fifo_din;
    byte_t     tdata_fifo_din;
    ns_t       counter_ns;
    ns_t       sync_delay;
    logic      gtx_dv;
    byte_t     gtx_d;

    int   mismatches;
    int   other_errors;
    int   frames_seen;
    logic timed_out;

    `include "tb_mac_tx_model.svh"

    mac_tx_gmii dut (
        .tx_master_clk    (tx_master_clk),
        .rstn_mac         (rstn_mac),
        .ptr_fifo_rd      (ptr_fifo_rd),
        .ptr_fifo_din     (ptr_fifo_din),
        .ptr_fifo_empty   (ptr_fifo_empty),
        .data_fifo_rd     (data_fifo_rd),
        .data_fifo_din    (data_fifo_din),
        .data_fifo_empty  (data_fifo_empty),
        .tptr_fifo_rd     (tptr_fifo_rd),
        .tptr_fifo_din    (tptr_fifo_din),
        .tptr_fifo_empty  (tptr_fifo_empty),
        .tdata_fifo_rd    (tdata_fifo_rd),
        .tdata_fifo_din   (tdata_fifo_din),
        .tdata_fifo_empty (tdata_fifo_empty),
        .counter_ns       (counter_ns),
        .sync_delay       (sync_delay),
        .gtx_dv           (gtx_dv),
        .gtx_d            (gtx_d)
    );

    initial tx_master_clk = 1'b0;
    always #5 tx_master_clk = ~tx_master_clk;

    ////////////////////////////////////////
    // fifo models with registered outputs
    ////////////////////////////////////////
    ptr_word_t nptr_q[$];
    ptr_word_t tptr_q[$];
    byte_t     ndata_q[$];
    byte_t     tdata_q[$];
    logic      rd_p;
    logic      rd_tp;
    logic      rd_d;
    logic      rd_td;

    function automatic void update_flags();
        ptr_fifo_empty   = (nptr_q.size() == 0);
        tptr_fifo_empty  = (tptr_q.size() == 0);
        data_fifo_empty  = (ndata_q.size() == 0);
        tdata_fifo_empty = (tdata_q.size() == 0);
    endfunction

    function automatic void report_underflow(string fifo_name);
        $display("ERROR at %0t ns: read strobe on the empty %s FIFO", $time, fifo_name);
        other_errors++;
    endfunction

    always @(negedge tx_master_clk) begin
        rd_p  = ptr_fifo_rd;            // strobes are stable mid cycle
        rd_tp = tptr_fifo_rd;
        rd_d  = data_fifo_rd;
        rd_td = tdata_fifo_rd;
        @(posedge tx_master_clk);
        #1;
        if (rd_p) begin
            if (nptr_q.size() == 0) report_underflow("normal pointer");
            else ptr_fifo_din = nptr_q.pop_front();
        end
        if (rd_tp) begin
            if (tptr_q.size() == 0) report_underflow("time-triggered pointer");
            else tptr_fifo_din = tptr_q.pop_front();
        end
        if (rd_d) begin
            if (ndata_q.size() == 0) report_underflow("normal data");
            else data_fifo_din = ndata_q.pop_front();
        end
        if (rd_td) begin
            if (tdata_q.size() == 0) report_underflow("time-triggered data");
            else tdata_fifo_din = tdata_q.pop_front();
        end
        update_flags();
    end

    // bytes go in before the pointer that promises them
    task automatic push_frame(int k);
        for (int i = 0; i < int'(frm_len[k]); i++) begin
            if (frm_tt[k]) tdata_q.push_back(frm[k][i]);
            else ndata_q.push_back(frm[k][i]);
        end
        if (frm_tt[k]) tptr_q.push_back({5'($urandom), frm_len[k]});
        else nptr_q.push_back({5'($urandom), frm_len[k]});
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_byte(int pos, byte_t got, byte_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: gmii byte %0d got %h expected %h", $time, pos, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_len(frame_len_t got, frame_len_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: frame length got %0d expected %0d", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_delay(ns_t got, ns_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: sync_delay got %h expected %h", $time, got, exp);
            mismatches++;
        end
    endtask

    ////////////////////////////////////////
    // gmii monitor
    ////////////////////////////////////////
    task automatic expect_frame(int k, logic gap_due);
        byte_t rx [MAX_RX];
        int    low_cnt;
        int    n_rx;
        build_wire(k, counter_ns);
        low_cnt = 0;
        while (!gtx_dv && low_cnt < RX_TIMEOUT) begin
            low_cnt++;
            @(negedge tx_master_clk);
        end
        if (!gtx_dv) begin
            $display("ERROR at %0t ns: no frame started on GMII within %0d cycles",
                     $time, RX_TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
            return;
        end
        if (gap_due && low_cnt < IFG_CYCLES) begin
            $display("ERROR at %0t ns: gap before this frame was only %0d cycles", $time, low_cnt);
            other_errors++;
        end
        n_rx = 0;
        while (gtx_dv && n_rx < MAX_RX) begin
            rx[n_rx] = gtx_d;
            n_rx++;
            @(negedge tx_master_clk);
        end
        if (gtx_dv) begin
            $display("ERROR at %0t ns: gtx_dv stayed high for over %0d cycles", $time, MAX_RX);
            other_errors++;
            timed_out = 1'b1;
            return;
        end
        frames_seen++;
        check_len(frame_len_t'(n_rx - PREAMBLE_LEN - CRC_LEN), frm_len[k]);
        for (int i = 0; i < n_rx && i < wire_len; i++) begin
            check_byte(i, rx[i], wire_exp[i]);
        end
        if (frm_kind[k] == 1) check_delay(sync_delay, model_delay);
    endtask

    // 1 to 4 frames pushed at once with tt frames due first
    task automatic run_batch();
        int order [MAX_BATCH];
        int n;
        int n_ord;
        int r;
        @(posedge tx_master_clk);
        #1;
        counter_ns = ns_t'($urandom);   // only moves while the line is idle
        n = $urandom_range(1, MAX_BATCH);
        for (int k = 0; k < n; k++) begin
            r = $urandom_range(0, 5);
            make_frame(k, (r < 2) ? 1 : (r < 4) ? 2 : (r == 4) ? 0 : 3,
                       frame_len_t'($urandom_range(MIN_FRAME_LEN, 200)));
            frm_tt[k] = 1'($urandom_range(0, 1));
            push_frame(k);
        end
        update_flags();
        n_ord = 0;
        for (int pass = 1; pass >= 0; pass--) begin
            for (int k = 0; k < n; k++) begin
                if (frm_tt[k] == 1'(pass)) begin
                    order[n_ord] = k;
                    n_ord++;
                end
            end
        end
        for (int i = 0; i < n && !timed_out; i++) begin
            expect_frame(order[i], frames_seen > 0);
        end
    endtask

    task automatic check_idle_after_reset();
        check_delay(sync_delay, '0);
        repeat (20) begin
            @(negedge tx_master_clk);
            if (gtx_dv || (gtx_d != 8'h00) || ptr_fifo_rd || tptr_fifo_rd
                || data_fifo_rd || tdata_fifo_rd) begin
                $display("ERROR at %0t ns: GMII or a FIFO read active before any pointer",
                         $time);
                other_errors++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'he5d7_84aa));
        rstn_mac       = 1'b0;
        ptr_fifo_din   = '0;
        tptr_fifo_din  = '0;
        data_fifo_din  = '0;
        tdata_fifo_din = '0;
        counter_ns     = '0;
        model_delay    = '0;
        mismatches     = 0;
        other_errors   = 0;
        frames_seen    = 0;
        timed_out      = 1'b0;
        update_flags();
        repeat (8) @(posedge tx_master_clk);
        #1;
        rstn_mac = 1'b1;
        check_idle_after_reset();
        for (int b = 0; b < N_BATCHES && !timed_out; b++) begin
            run_batch();
        end
        $display("tb_mac_tx: %0d frames, %0d mismatches, %0d other errors",
                 frames_seen, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
common/mac_tx_pkg.sv
verilog/crc32_8023.sv
verilog/mac_tx_emit.sv
ptp/ptp_tx_parser.sv
ptp/ptp_cf_rewrite.sv
fetch/mac_tx_fetch.sv
verilog/mac_tx_gmii.sv
verif/tb_mac_tx.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mac_tx -f tb.f \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_mac_tx > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
